//--- tb/retire_trace.txt
# C ack ex pc0 pc1 priv dbg ready   (ack, ex as {port1,port0} binary, ready 2 = random)
# R addr expected pslverr | M addr pslverr (model value) | W addr data pslverr | D drain
# single and dual retirements, mode tags, exceptions
C 01 00 80000000 0 3 0 1
C 11 00 80000004 80000008 3 0 1
C 11 00 8000000c 80000010 1 0 1
C 10 00 0 80000014 0 0 1
C 11 00 80000018 8000001c 0 0 2
C 00 00 0 0 0 0 2
C 11 00 80000020 80000024 3 1 2
C 01 00 80000028 0 1 1 1
C 11 01 80000100 8000002c 3 0 1
C 11 11 80000104 80000108 1 0 1
C 10 10 0 8000010c 0 0 1
C 01 00 80000030 0 0 0 1
D
R 04 0000000d 0
R 08 00000004 0
R 0c 00000000 0
R 10 00000000 0
# long back-pressure, FIFO fills and drops the rest
C 11 00 80000200 80000204 0 0 0
C 11 00 80000208 8000020c 1 0 0
C 11 00 80000210 80000214 3 0 0
C 11 00 80000218 8000021c 0 0 0
C 11 00 80000220 80000224 1 0 0
C 11 00 80000228 8000022c 3 0 0
C 11 00 80000230 80000234 0 1 0
C 01 00 80000238 0 3 0 0
R 10 00000008 0
R 0c 00000007 0
D
R 0c 00000007 0
M 0c 0
R 04 0000001c 0
R 10 00000000 0
# instret write, then bad accesses
W 04 00001000 0
C 11 00 80000400 80000404 3 0 1
C 01 00 80000408 0 3 0 1
R 04 00001003 0
M 04 0
R 20 00000000 1
W 10 00000005 1
W 40 00000001 1
R 10 00000000 0
# cycle counter stops while in debug
M 00 0
C 00 00 0 0 3 1 1
C 00 00 0 0 3 1 1
C 00 00 0 0 3 1 1
M 00 0
C 01 00 80000500 0 1 1 1
C 00 00 0 0 0 0 1
M 00 0
D
M 0c 0
R 0c 00000007 0
R 08 00000004 0
M 04 0
R 04 00001004 0

//--- project.f
hw/retire_pkg.sv
hw/commit_capture.sv
hw/retire_fifo.sv
hw/perf_counters.sv
hw/apb_regs.sv
hw/retire_trace_top.sv
tb/tb_retire_trace.sv

//--- tb/tb_retire_trace.sv
// testbench for the retirement trace unit, replays the commit trace file and checks trace and counters
module tb_retire_trace;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned FifoDepth    = 8;
  localparam int unsigned DrainTimeout = 200;

  logic                                               clk_i = 1'b0;
  logic                                               rst_ni;
  logic               [retire_pkg::NR_COMMIT_PORTS-1:0] commit_ack_i;
  retire_pkg::pc_t    [retire_pkg::NR_COMMIT_PORTS-1:0] commit_pc_i;
  logic               [retire_pkg::NR_COMMIT_PORTS-1:0] commit_ex_valid_i;
  retire_pkg::cause_t [retire_pkg::NR_COMMIT_PORTS-1:0] commit_cause_i;
  retire_pkg::priv_lvl_e                              priv_lvl_i;
  logic                                               debug_mode_i;
  logic                                               trace_ready_i;
  logic                                               trace_valid_o;
  retire_pkg::pc_t                                    trace_pc_o;
  retire_pkg::mode_e                                  trace_mode_o;
  retire_pkg::apb_addr_t                              paddr_i;
  logic                                               psel_i;
  logic                                               penable_i;
  logic                                               pwrite_i;
  retire_pkg::cnt_t                                   pwdata_i;
  retire_pkg::cnt_t                                   prdata_o;
  logic                                               pready_o;
  logic                                               pslverr_o;

  int unsigned       errors;
  int unsigned       timeouts;
  int unsigned       retired_total;
  int unsigned       delivered_total;
  int unsigned       nondebug_edges;
  int unsigned       edges_at_read;
  int unsigned       prev_cycle_edges;
  retire_pkg::cnt_t  prev_cycle_read;
  retire_pkg::cnt_t  model_instret;
  retire_pkg::cnt_t  model_except;
  retire_pkg::pc_t   ref_pc_q[$];
  retire_pkg::mode_e ref_mode_q[$];
  int                fd;
  int                code;
  logic [8*160-1:0]  comment_line;

  retire_trace_top #(
    .FifoDepth ( FifoDepth )
  ) dut0 (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .commit_cause_i    ( commit_cause_i    ),
    .priv_lvl_i        ( priv_lvl_i        ),
    .debug_mode_i      ( debug_mode_i      ),
    .trace_ready_i     ( trace_ready_i     ),
    .trace_valid_o     ( trace_valid_o     ),
    .trace_pc_o        ( trace_pc_o        ),
    .trace_mode_o      ( trace_mode_o      ),
    .paddr_i           ( paddr_i           ),
    .psel_i            ( psel_i            ),
    .penable_i         ( penable_i         ),
    .pwrite_i          ( pwrite_i          ),
    .pwdata_i          ( pwdata_i          ),
    .prdata_o          ( prdata_o          ),
    .pready_o          ( pready_o          ),
    .pslverr_o         ( pslverr_o         )
  );

  always #2 clk_i = ~clk_i;

  // edges on which the cycle counter is allowed to advance
  always @(posedge clk_i) begin
    if (rst_ni && !debug_mode_i) begin
      nondebug_edges++;
    end
  end

  // ----------------------------------------------------------
  // checks and reference model
  // ----------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      errors++;
      $display("CHECK FAILED: %s expected %h got %h", name, exp, act);
    end
  endtask

  function automatic retire_pkg::mode_e expected_mode(input int priv, input int dbg);
    if (dbg != 0) begin
      return retire_pkg::MODE_D;
    end
    case (priv)
      0:       return retire_pkg::MODE_U;
      1:       return retire_pkg::MODE_S;
      default: return retire_pkg::MODE_M;
    endcase
  endfunction

  // each delivered pc must be the oldest one still expected
  task automatic check_trace_entry(input retire_pkg::pc_t pc, input retire_pkg::mode_e mode);
    retire_pkg::pc_t   exp_pc;
    retire_pkg::mode_e exp_mode;
    delivered_total++;
    assert (ref_pc_q.size() != 0) else begin
      errors++;
      $display("trace output delivered pc %h while nothing was waiting to retire", pc);
    end
    if (ref_pc_q.size() != 0) begin
      exp_pc   = ref_pc_q.pop_front();
      exp_mode = ref_mode_q.pop_front();
      check_value("trace_pc_o", exp_pc, pc);
      check_value("trace_mode_o", exp_mode, mode);
    end
  endtask

  // valid and ready are stable at the falling edge, transfer follows on the rising one
  always @(negedge clk_i) begin
    if (rst_ni && trace_valid_o && trace_ready_i) begin
      check_trace_entry(trace_pc_o, trace_mode_o);
    end
  end

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------
  task automatic apply_cycle();
    logic [1:0]      ack;
    logic [1:0]      ex;
    retire_pkg::pc_t pc0;
    retire_pkg::pc_t pc1;
    int              priv;
    int              dbg;
    int              rdy;
    int              n;
    n = $fscanf(fd, "%b %b %h %h %d %d %d", ack, ex, pc0, pc1, priv, dbg, rdy);
    if (n != 7) begin
      errors++;
      $display("malformed cycle record in the trace file");
    end else begin
      @(posedge clk_i);
      commit_ack_i      <= ack;
      commit_ex_valid_i <= ex;
      commit_pc_i[0]    <= pc0;
      commit_pc_i[1]    <= pc1;
      commit_cause_i[0] <= ex[0] ? 6'h02 : 6'h00;
      commit_cause_i[1] <= ex[1] ? 6'h02 : 6'h00;
      priv_lvl_i        <= retire_pkg::priv_lvl_e'(priv[1:0]);
      debug_mode_i      <= dbg[0];
      trace_ready_i     <= (rdy == 2) ? (($urandom % 2) == 1) : rdy[0];
      // port 0 retires ahead of port 1
      if (ack[0] && !ex[0]) begin
        ref_pc_q.push_back(pc0);
        ref_mode_q.push_back(expected_mode(priv, dbg));
        retired_total++;
        model_instret++;
      end
      if (ack[1] && !ex[1]) begin
        ref_pc_q.push_back(pc1);
        ref_mode_q.push_back(expected_mode(priv, dbg));
        retired_total++;
        model_instret++;
      end
      model_except = model_except + (ack[0] & ex[0]) + (ack[1] & ex[1]);
    end
  endtask

  // fixed APB timing, one setup and one access cycle
  task automatic apb_transfer(input logic wr, input retire_pkg::apb_addr_t addr,
                              input retire_pkg::cnt_t wdata,
                              output retire_pkg::cnt_t rdata, output logic err);
    @(posedge clk_i);
    commit_ack_i      <= '0;
    commit_ex_valid_i <= '0;
    psel_i            <= 1'b1;
    penable_i         <= 1'b0;
    pwrite_i          <= wr;
    paddr_i           <= addr;
    pwdata_i          <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    check_value("pready_o", 64'd1, pready_o);
    rdata         = prdata_o;
    err           = pslverr_o;
    edges_at_read = nondebug_edges;
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  task automatic read_register(input bit use_model);
    retire_pkg::apb_addr_t addr;
    retire_pkg::cnt_t      exp;
    retire_pkg::cnt_t      rdata;
    logic                  err;
    int                    err_exp;
    int                    n;
    exp = '0;
    if (use_model) begin
      n = $fscanf(fd, "%h %d", addr, err_exp) + 1;
    end else begin
      n = $fscanf(fd, "%h %h %d", addr, exp, err_exp);
    end
    if (n != 3) begin
      errors++;
      $display("malformed register read in the trace file");
    end else begin
      apb_transfer(1'b0, addr, '0, rdata, err);
      check_value("pslverr_o", err_exp, err);
      if (use_model) begin
        case (addr)
          retire_pkg::REG_CYCLE: begin
            // advance since the previous read, debug edges excluded
            exp              = prev_cycle_read + (edges_at_read - prev_cycle_edges);
            prev_cycle_read  = exp;
            prev_cycle_edges = edges_at_read;
          end
          retire_pkg::REG_INSTRET: exp = model_instret;
          retire_pkg::REG_EXCEPT:  exp = model_except;
          retire_pkg::REG_DROPPED: exp = retired_total - delivered_total;
          default: begin
            errors++;
            $display("no reference value for register address %h", addr);
          end
        endcase
      end
      if (err_exp == 0) begin
        check_value($sformatf("prdata_o (addr %h)", addr), exp, rdata);
      end
    end
  endtask

  task automatic write_register();
    retire_pkg::apb_addr_t addr;
    retire_pkg::cnt_t      wdata;
    retire_pkg::cnt_t      rdata;
    logic                  err;
    int                    err_exp;
    int                    n;
    n = $fscanf(fd, "%h %h %d", addr, wdata, err_exp);
    if (n != 3) begin
      errors++;
      $display("malformed register write in the trace file");
    end else begin
      apb_transfer(1'b1, addr, wdata, rdata, err);
      check_value("pslverr_o", err_exp, err);
      if (err_exp == 0 && addr == retire_pkg::REG_INSTRET) begin
        model_instret = wdata;
      end else if (err_exp == 0 && addr == retire_pkg::REG_EXCEPT) begin
        model_except = wdata;
      end
    end
  endtask

  task automatic drain_trace();
    int unsigned waited;
    @(posedge clk_i);
    commit_ack_i      <= '0;
    commit_ex_valid_i <= '0;
    trace_ready_i     <= 1'b1;
    // last commit lands in the FIFO two edges after it was driven
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    waited = 0;
    while (trace_valid_o && waited < DrainTimeout) begin
      waited++;
      @(negedge clk_i);
    end
    if (trace_valid_o) begin
      timeouts++;
      $display("timeout: trace output still valid after %0d cycles of draining", DrainTimeout);
    end
    // what is still expected never made it into the full FIFO
    ref_pc_q.delete();
    ref_mode_q.delete();
  endtask

  initial begin
    rst_ni            = 1'b0;
    commit_ack_i      = '0;
    commit_pc_i       = '0;
    commit_ex_valid_i = '0;
    commit_cause_i    = '0;
    priv_lvl_i        = retire_pkg::PRIV_LVL_M;
    debug_mode_i      = 1'b0;
    trace_ready_i     = 1'b0;
    paddr_i           = '0;
    psel_i            = 1'b0;
    penable_i         = 1'b0;
    pwrite_i          = 1'b0;
    pwdata_i          = '0;
    prev_cycle_read   = '0;
    model_instret     = '0;
    model_except      = '0;
    void'($urandom(32'haacc_8a96));
    fd = $fopen("tb/retire_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the trace file tb/retire_trace.txt");
    end else begin
      repeat (3) @(posedge clk_i);
      rst_ni <= 1'b1;
      while (timeouts == 0 && $fscanf(fd, " %c", code) == 1) begin
        case (code)
          "#": void'($fgets(comment_line, fd));
          "C": apply_cycle();
          "R": read_register(1'b0);
          "M": read_register(1'b1);
          "W": write_register();
          "D": drain_trace();
          default: begin
            errors++;
            $display("unknown command in the trace file");
          end
        endcase
      end
      $fclose(fd);
    end
    $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- hw/retire_trace_top.sv
// top level of the retirement trace unit, connects capture, FIFO, counters and APB block
module retire_trace_top #(
  parameter int unsigned FifoDepth = 8
) (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  // commit ports
  input  logic               [retire_pkg::NR_COMMIT_PORTS-1:0] commit_ack_i,
  input  retire_pkg::pc_t    [retire_pkg::NR_COMMIT_PORTS-1:0] commit_pc_i,
  input  logic               [retire_pkg::NR_COMMIT_PORTS-1:0] commit_ex_valid_i,
  input  retire_pkg::cause_t [retire_pkg::NR_COMMIT_PORTS-1:0] commit_cause_i,
  input  retire_pkg::priv_lvl_e                              priv_lvl_i,
  input  logic                                               debug_mode_i,
  // trace output
  input  logic                                               trace_ready_i,
  output logic                                               trace_valid_o,
  output retire_pkg::pc_t                                    trace_pc_o,
  output retire_pkg::mode_e                                  trace_mode_o,
  // APB
  input  retire_pkg::apb_addr_t                              paddr_i,
  input  logic                                               psel_i,
  input  logic                                               penable_i,
  input  logic                                               pwrite_i,
  input  retire_pkg::cnt_t                                   pwdata_i,
  output retire_pkg::cnt_t                                   prdata_o,
  output logic                                               pready_o,
  output logic                                               pslverr_o
);

  // ----------------------------------------------------------
  // capture to FIFO and counters
  // ----------------------------------------------------------
  logic              [retire_pkg::NR_COMMIT_PORTS-1:0] retire_valid;
  logic              [retire_pkg::NR_COMMIT_PORTS-1:0] except_valid;
  retire_pkg::pc_t   [retire_pkg::NR_COMMIT_PORTS-1:0] retire_pc;
  retire_pkg::mode_e [retire_pkg::NR_COMMIT_PORTS-1:0] retire_mode;

  // FIFO status
  retire_pkg::fifo_level_t fifo_level;
  logic [1:0]              drop_count;

  // counters <-> register block
  logic                  reg_we;
  retire_pkg::apb_addr_t reg_addr;
  retire_pkg::cnt_t      reg_wdata;
  retire_pkg::cnt_t      cycle_cnt;
  retire_pkg::cnt_t      instret_cnt;
  retire_pkg::cnt_t      except_cnt;
  retire_pkg::cnt_t      dropped_cnt;

  commit_capture i_commit_capture (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_cause_i    ( commit_cause_i    ),
    .priv_lvl_i        ( priv_lvl_i        ),
    .debug_mode_i      ( debug_mode_i      ),
    .retire_valid_o    ( retire_valid      ),
    .except_valid_o    ( except_valid      ),
    .retire_pc_o       ( retire_pc         ),
    .retire_mode_o     ( retire_mode       )
  );

  retire_fifo #(
    .FifoDepth ( FifoDepth )
  ) i_retire_fifo (
    .clk_i          ( clk_i         ),
    .rst_ni         ( rst_ni        ),
    .retire_valid_i ( retire_valid  ),
    .retire_pc_i    ( retire_pc     ),
    .retire_mode_i  ( retire_mode   ),
    .trace_ready_i  ( trace_ready_i ),
    .trace_valid_o  ( trace_valid_o ),
    .trace_pc_o     ( trace_pc_o    ),
    .trace_mode_o   ( trace_mode_o  ),
    .level_o        ( fifo_level    ),
    .drop_count_o   ( drop_count    )
  );

  perf_counters i_perf_counters (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .debug_mode_i   ( debug_mode_i ),
    .retire_valid_i ( retire_valid ),
    .except_valid_i ( except_valid ),
    .drop_count_i   ( drop_count   ),
    .reg_we_i       ( reg_we       ),
    .reg_addr_i     ( reg_addr     ),
    .reg_wdata_i    ( reg_wdata    ),
    .cycle_o        ( cycle_cnt    ),
    .instret_o      ( instret_cnt  ),
    .except_o       ( except_cnt   ),
    .dropped_o      ( dropped_cnt  )
  );

  apb_regs i_apb_regs (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .paddr_i     ( paddr_i     ),
    .psel_i      ( psel_i      ),
    .penable_i   ( penable_i   ),
    .pwrite_i    ( pwrite_i    ),
    .pwdata_i    ( pwdata_i    ),
    .prdata_o    ( prdata_o    ),
    .pready_o    ( pready_o    ),
    .pslverr_o   ( pslverr_o   ),
    .reg_we_o    ( reg_we      ),
    .reg_addr_o  ( reg_addr    ),
    .reg_wdata_o ( reg_wdata   ),
    .cycle_i     ( cycle_cnt   ),
    .instret_i   ( instret_cnt ),
    .except_i    ( except_cnt  ),
    .dropped_i   ( dropped_cnt ),
    .level_i     ( fifo_level  )
  );

endmodule

//--- hw/apb_regs.sv
// APB slave for the trace unit, counter reads and writes plus the read-only FIFO level
module apb_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // APB
  input  retire_pkg::apb_addr_t   paddr_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  retire_pkg::cnt_t        pwdata_i,
  output retire_pkg::cnt_t        prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  // counter write port
  output logic                    reg_we_o,
  output retire_pkg::apb_addr_t   reg_addr_o,
  output retire_pkg::cnt_t        reg_wdata_o,
  // read sources
  input  retire_pkg::cnt_t        cycle_i,
  input  retire_pkg::cnt_t        instret_i,
  input  retire_pkg::cnt_t        except_i,
  input  retire_pkg::cnt_t        dropped_i,
  input  retire_pkg::fifo_level_t level_i
);

  logic             setup_q;
  logic             access;
  logic             addr_hit;
  logic             counter_hit;
  retire_pkg::cnt_t rdata;

  // setup phase seen on the previous edge, so each transfer gets one access cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= psel_i & ~penable_i;
    end
  end

  assign access = psel_i & penable_i & setup_q;

  // ----------------------------------------------------------
  // address decode and read mux
  // ----------------------------------------------------------
  always_comb begin
    rdata       = '0;
    addr_hit    = 1'b1;
    counter_hit = 1'b1;
    case (paddr_i)
      retire_pkg::REG_CYCLE:   rdata = cycle_i;
      retire_pkg::REG_INSTRET: rdata = instret_i;
      retire_pkg::REG_EXCEPT:  rdata = except_i;
      retire_pkg::REG_DROPPED: rdata = dropped_i;
      retire_pkg::REG_FIFO_LEVEL: begin
        rdata       = retire_pkg::cnt_t'(level_i);
        counter_hit = 1'b0;
      end
      default: begin
        addr_hit    = 1'b0;
        counter_hit = 1'b0;
      end
    endcase
  end

  // no wait states
  assign pready_o  = 1'b1;
  assign prdata_o  = (access && !pwrite_i) ? rdata : '0;
  assign pslverr_o = access & (~addr_hit | (pwrite_i & ~counter_hit));

  // write strobe towards the counters
  assign reg_we_o    = access & pwrite_i & counter_hit;
  assign reg_addr_o  = paddr_i;
  assign reg_wdata_o = pwdata_i;

endmodule

//--- hw/perf_counters.sv
// cycle, instret, exception and drop counters, each writable through the register block
module perf_counters (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   debug_mode_i,
  // events
  input  logic [retire_pkg::NR_COMMIT_PORTS-1:0] retire_valid_i,
  input  logic [retire_pkg::NR_COMMIT_PORTS-1:0] except_valid_i,
  input  logic [1:0]                             drop_count_i,
  // register write access
  input  logic                                   reg_we_i,
  input  retire_pkg::apb_addr_t                  reg_addr_i,
  input  retire_pkg::cnt_t                       reg_wdata_i,
  // counter values
  output retire_pkg::cnt_t                       cycle_o,
  output retire_pkg::cnt_t                       instret_o,
  output retire_pkg::cnt_t                       except_o,
  output retire_pkg::cnt_t                       dropped_o
);

  retire_pkg::cnt_t cycle_q;
  retire_pkg::cnt_t instret_q;
  retire_pkg::cnt_t except_q;
  retire_pkg::cnt_t dropped_q;
  logic             we_cycle;
  logic             we_instret;
  logic             we_except;
  logic             we_dropped;

  // number of ports flagged in a vector
  function automatic retire_pkg::cnt_t count_ports(
    input logic [retire_pkg::NR_COMMIT_PORTS-1:0] vec
  );
    retire_pkg::cnt_t n;
    n = '0;
    for (int i = 0; i < retire_pkg::NR_COMMIT_PORTS; i++) begin
      n = n + retire_pkg::cnt_t'(vec[i]);
    end
    return n;
  endfunction

  // ----------------------------------------------------------
  // write decode
  // ----------------------------------------------------------
  assign we_cycle   = reg_we_i && (reg_addr_i == retire_pkg::REG_CYCLE);
  assign we_instret = reg_we_i && (reg_addr_i == retire_pkg::REG_INSTRET);
  assign we_except  = reg_we_i && (reg_addr_i == retire_pkg::REG_EXCEPT);
  assign we_dropped = reg_we_i && (reg_addr_i == retire_pkg::REG_DROPPED);

  // ----------------------------------------------------------
  // counters, a write beats the increment
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q   <= '0;
      instret_q <= '0;
      except_q  <= '0;
      dropped_q <= '0;
    end else begin
      if (we_cycle) begin
        cycle_q <= reg_wdata_i;
      end else if (!debug_mode_i) begin
        cycle_q <= cycle_q + 32'd1;
      end

      if (we_instret) begin
        instret_q <= reg_wdata_i;
      end else begin
        instret_q <= instret_q + count_ports(retire_valid_i);
      end

      if (we_except) begin
        except_q <= reg_wdata_i;
      end else begin
        except_q <= except_q + count_ports(except_valid_i);
      end

      // drops arrive on the edge they happen
      if (we_dropped) begin
        dropped_q <= reg_wdata_i;
      end else begin
        dropped_q <= dropped_q + retire_pkg::cnt_t'(drop_count_i);
      end
    end
  end

  assign cycle_o   = cycle_q;
  assign instret_o = instret_q;
  assign except_o  = except_q;
  assign dropped_o = dropped_q;

endmodule

//--- hw/retire_fifo.sv
// two-write one-read FIFO that serializes retired pcs onto the valid/ready trace port
module retire_fifo #(
  parameter int unsigned FifoDepth = 8
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  // from commit capture
  input  logic              [retire_pkg::NR_COMMIT_PORTS-1:0] retire_valid_i,
  input  retire_pkg::pc_t   [retire_pkg::NR_COMMIT_PORTS-1:0] retire_pc_i,
  input  retire_pkg::mode_e [retire_pkg::NR_COMMIT_PORTS-1:0] retire_mode_i,
  // trace output, show-ahead head
  input  logic                                              trace_ready_i,
  output logic                                              trace_valid_o,
  output retire_pkg::pc_t                                   trace_pc_o,
  output retire_pkg::mode_e                                 trace_mode_o,
  // status
  output retire_pkg::fifo_level_t                           level_o,
  output logic [1:0]                                        drop_count_o
);

  localparam int unsigned AddrWidth = $clog2(FifoDepth);

  typedef logic [AddrWidth-1:0] ptr_t;

  // storage, payload only
  retire_pkg::pc_t   pc_mem_q   [FifoDepth];
  retire_pkg::mode_e mode_mem_q [FifoDepth];

  ptr_t                    rd_ptr_q;
  ptr_t                    wr_ptr_q;
  ptr_t                    wr_addr1;
  retire_pkg::fifo_level_t count_q;
  retire_pkg::fifo_level_t free_slots;
  logic                    pop;
  logic                    accept0;
  logic                    accept1;

  // ----------------------------------------------------------
  // read side
  // ----------------------------------------------------------
  assign trace_valid_o = (count_q != '0);
  assign trace_pc_o    = pc_mem_q[rd_ptr_q];
  assign trace_mode_o  = mode_mem_q[rd_ptr_q];
  assign pop           = trace_valid_o & trace_ready_i;
  assign level_o       = count_q;

  // ----------------------------------------------------------
  // write side
  // ----------------------------------------------------------
  // space after this edge's pop, port 0 takes the first slot
  assign free_slots = retire_pkg::fifo_level_t'(FifoDepth) - count_q
                    + retire_pkg::fifo_level_t'(pop);

  assign accept0 = retire_valid_i[0] & (free_slots != '0);
  assign accept1 = retire_valid_i[1]
                 & (free_slots > retire_pkg::fifo_level_t'(accept0));

  // port 1 lands behind port 0 when both are written
  assign wr_addr1 = wr_ptr_q + ptr_t'(accept0);

  // entries that found no slot on this edge
  assign drop_count_o = {1'b0, retire_valid_i[0] & ~accept0}
                      + {1'b0, retire_valid_i[1] & ~accept1};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
      wr_ptr_q <= wr_ptr_q + ptr_t'(accept0) + ptr_t'(accept1);
      count_q  <= count_q - retire_pkg::fifo_level_t'(pop)
                + retire_pkg::fifo_level_t'(accept0)
                + retire_pkg::fifo_level_t'(accept1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept0) begin
      pc_mem_q[wr_ptr_q]   <= retire_pc_i[0];
      mode_mem_q[wr_ptr_q] <= retire_mode_i[0];
    end
    if (accept1) begin
      pc_mem_q[wr_addr1]   <= retire_pc_i[1];
      mode_mem_q[wr_addr1] <= retire_mode_i[1];
    end
  end

endmodule

//--- hw/commit_capture.sv
// input stage of the trace unit, registers both commit ports and tags each with its mode
module commit_capture (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  // commit side
  input  logic              [retire_pkg::NR_COMMIT_PORTS-1:0] commit_ack_i,
  input  logic              [retire_pkg::NR_COMMIT_PORTS-1:0] commit_ex_valid_i,
  input  retire_pkg::pc_t   [retire_pkg::NR_COMMIT_PORTS-1:0] commit_pc_i,
  input  retire_pkg::cause_t [retire_pkg::NR_COMMIT_PORTS-1:0] commit_cause_i,
  input  retire_pkg::priv_lvl_e                             priv_lvl_i,
  input  logic                                              debug_mode_i,
  // captured entries
  output logic              [retire_pkg::NR_COMMIT_PORTS-1:0] retire_valid_o,
  output logic              [retire_pkg::NR_COMMIT_PORTS-1:0] except_valid_o,
  output retire_pkg::pc_t   [retire_pkg::NR_COMMIT_PORTS-1:0] retire_pc_o,
  output retire_pkg::mode_e [retire_pkg::NR_COMMIT_PORTS-1:0] retire_mode_o
);

  logic [retire_pkg::NR_COMMIT_PORTS-1:0] retire_d;
  logic [retire_pkg::NR_COMMIT_PORTS-1:0] except_d;
  retire_pkg::mode_e                      mode_d;

  // ----------------------------------------------------------
  // classification
  // ----------------------------------------------------------
  // the cause code stays behind here, an exception is only counted
  assign retire_d = commit_ack_i & ~commit_ex_valid_i;
  assign except_d = commit_ack_i & commit_ex_valid_i;

  // one mode for both ports, debug wins over privilege
  always_comb begin
    if (debug_mode_i) begin
      mode_d = retire_pkg::MODE_D;
    end else begin
      case (priv_lvl_i)
        retire_pkg::PRIV_LVL_U: mode_d = retire_pkg::MODE_U;
        retire_pkg::PRIV_LVL_S: mode_d = retire_pkg::MODE_S;
        retire_pkg::PRIV_LVL_M: mode_d = retire_pkg::MODE_M;
        // reserved encoding, treat as machine
        default:                mode_d = retire_pkg::MODE_M;
      endcase
    end
  end

  // ----------------------------------------------------------
  // capture register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_valid_o <= '0;
      except_valid_o <= '0;
      for (int i = 0; i < retire_pkg::NR_COMMIT_PORTS; i++) begin
        retire_pc_o[i]   <= '0;
        retire_mode_o[i] <= retire_pkg::MODE_U;
      end
    end else begin
      retire_valid_o <= retire_d;
      except_valid_o <= except_d;
      for (int i = 0; i < retire_pkg::NR_COMMIT_PORTS; i++) begin
        retire_pc_o[i]   <= commit_pc_i[i];
        retire_mode_o[i] <= mode_d;
      end
    end
  end

endmodule

//--- hw/retire_pkg.sv
// shared widths, types, mode tags and register offsets of the retirement trace unit
package retire_pkg;

  // ----------------------------------------------------------
  // sizes and plain vector types
  // ----------------------------------------------------------
  localparam int unsigned NR_COMMIT_PORTS = 2;

  typedef logic [63:0] pc_t;
  // only counted, never traced
  typedef logic [5:0]  cause_t;
  typedef logic [31:0] cnt_t;
  typedef logic [7:0]  apb_addr_t;
  // occupancy, wide enough for depths up to 128
  typedef logic [7:0]  fifo_level_t;

  // ----------------------------------------------------------
  // privilege and trace mode
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_S = 2'd1,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

  // tag carried with each traced pc, debug overrides privilege
  typedef enum logic [2:0] {
    MODE_U = 3'd0,
    MODE_S = 3'd1,
    MODE_M = 3'd2,
    MODE_D = 3'd3
  } mode_e;

  // ----------------------------------------------------------
  // register map, byte offsets
  // ----------------------------------------------------------
  localparam apb_addr_t REG_CYCLE      = 8'h00;
  localparam apb_addr_t REG_INSTRET    = 8'h04;
  localparam apb_addr_t REG_EXCEPT     = 8'h08;
  localparam apb_addr_t REG_DROPPED    = 8'h0C;
  // read only
  localparam apb_addr_t REG_FIFO_LEVEL = 8'h10;

endpackage
